// ==== bench/vector_unit_chk.sv ====
// Concurrent assertions on valid timing, reset state and config update
// Bound into the vector unit top level
module vector_unit_chk (
    input logic                      clk_i,
    input logic                      reset_i,
    input logic                      cfg_write_i,
    input vector_unit_pkg::vec_len_t cfg_vector_length_i,
    input logic                      cfg_signed_i,
    input logic                      data_valid_i,
    input logic                      valid_i,
    input vector_unit_pkg::vec_len_t vector_length_i,
    input logic                      signed_operation_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // A strobe shows up on valid_o exactly one edge later
    valid_follows_strobe : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> (valid_i == $past(data_valid_i))
    ) else $error("valid_o does not follow data_valid_i by one cycle");

    // The output stage comes out of reset idle
    valid_low_after_reset : assert property (
        @(posedge clk_i) $past(reset_i) |-> !valid_i
    ) else $error("valid_o is high in the cycle after reset");

    // The control register takes the written values at the next edge
    config_write_lands : assert property (
        @(posedge clk_i) disable iff (reset_i)
        cfg_write_i |=> (vector_length_i == $past(cfg_vector_length_i))
                        && (signed_operation_i == $past(cfg_signed_i))
    ) else $error("control register does not hold the written configuration");

endmodule : vector_unit_chk

bind vector_unit vector_unit_chk u_chk (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cfg_write_i         (cfg_write_i),
    .cfg_vector_length_i (cfg_vector_length_i),
    .cfg_signed_i        (cfg_signed_i),
    .data_valid_i        (data_valid_i),
    .valid_i             (valid_o),
    .vector_length_i     (vector_length),
    .signed_operation_i  (signed_operation)
);

// ==== bench/vector_unit_tb.sv ====
// Testbench of the packed-SIMD vector unit
// Reads test vectors from a data file, drives the DUT and checks every result
module vector_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Cycles to wait for valid_o before an operation is given up
    localparam int VALID_TIMEOUT = 20;

    logic                       clk;
    logic                       reset;
    logic                       cfg_write;
    vector_unit_pkg::vec_len_t  cfg_vector_length;
    logic                       cfg_signed;
    vector_unit_pkg::vector_t   operand_a;
    vector_unit_pkg::vector_t   operand_b;
    vector_unit_pkg::vunit_op_t operation;
    logic                       data_valid;
    vector_unit_pkg::vector_t   result;
    logic                       valid;

    // One entry per test line of the data file
    string                      test_name[$];
    bit                         test_cfg_write[$];
    vector_unit_pkg::vec_len_t  test_length[$];
    bit                         test_signed[$];
    vector_unit_pkg::vunit_op_t test_op[$];
    vector_unit_pkg::vector_t   test_a[$];
    vector_unit_pkg::vector_t   test_b[$];
    vector_unit_pkg::vector_t   test_expected[$];

    int                         error_count = 0;
    int                         check_count = 0;
    // Last result seen on valid_o, which result_o must hold while idle
    vector_unit_pkg::vector_t   last_expected;
    bit                         have_result = 1'b0;

    vector_unit u_dut (
        .clk_i               (clk),
        .reset_i             (reset),
        .cfg_write_i         (cfg_write),
        .cfg_vector_length_i (cfg_vector_length),
        .cfg_signed_i        (cfg_signed),
        .operand_a_i         (operand_a),
        .operand_b_i         (operand_b),
        .operation_i         (operation),
        .data_valid_i        (data_valid),
        .result_o            (result),
        .valid_o             (valid)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic compare_value(input string name,
                                 input vector_unit_pkg::vector_t expected,
                                 input vector_unit_pkg::vector_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_tests();
        int                       fd;
        int                       fields;
        int                       wr;
        int                       len;
        int                       sgn;
        int                       op;
        string                    line;
        string                    name;
        vector_unit_pkg::vector_t a;
        vector_unit_pkg::vector_t b;
        vector_unit_pkg::vector_t expected;
        fd = $fopen("bench/vector_unit_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file bench/vector_unit_tests.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Blank lines and comment lines carry no test
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %d %d %d %d %h %h %h",
                             name, wr, len, sgn, op, a, b, expected);
            if (fields != 8) begin
                $display("malformed line in the test vector file: %s", line);
                error_count++;
                continue;
            end
            test_name.push_back(name);
            test_cfg_write.push_back(wr != 0);
            test_length.push_back(vector_unit_pkg::vec_len_t'(len));
            test_signed.push_back(sgn != 0);
            test_op.push_back(vector_unit_pkg::vunit_op_t'(op));
            test_a.push_back(a);
            test_b.push_back(b);
            test_expected.push_back(expected);
        end
        $fclose(fd);
    endtask

    // Config values are driven with every operation too, but they only
    // reach the control register in a write cycle
    task automatic drive_op(input int idx);
        cfg_vector_length = test_length[idx];
        cfg_signed        = test_signed[idx];
        operand_a         = test_a[idx];
        operand_b         = test_b[idx];
        operation         = test_op[idx];
        data_valid        = 1'b1;
    endtask

    // A write gets a cycle of its own, with no operation beside it
    task automatic write_config(input int idx);
        cfg_write         = 1'b1;
        cfg_vector_length = test_length[idx];
        cfg_signed        = test_signed[idx];
        data_valid        = 1'b0;
        @(negedge clk);
        cfg_write = 1'b0;
        compare_value({test_name[idx], "_idle_valid"}, '0, vector_unit_pkg::vector_t'(valid));
        if (have_result) begin
            compare_value({test_name[idx], "_idle_hold"}, last_expected, result);
        end
    endtask

    // Called on the falling edge after the strobe, where valid_o should already be up
    task automatic collect_result(input int idx);
        int waited;
        waited = 0;
        while (!valid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!valid) begin
            $display("timeout: valid_o never rose for test %s", test_name[idx]);
            error_count++;
        end else begin
            compare_value(test_name[idx], test_expected[idx], result);
            compare_value({test_name[idx], "_latency"}, '0, vector_unit_pkg::vector_t'(waited));
            last_expected = test_expected[idx];
            have_result   = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        int idx;
        clk               = 1'b0;
        reset             = 1'b1;
        cfg_write         = 1'b0;
        cfg_vector_length = vector_unit_pkg::VEC_LEN_16;
        cfg_signed        = 1'b0;
        // An operation is offered while reset is high, and the output
        // stage must stay cleared in spite of it
        operand_a         = 32'h0001_0001;
        operand_b         = 32'h0001_0001;
        operation         = vector_unit_pkg::OP_ADD;
        data_valid        = 1'b1;
        last_expected     = '0;
        load_tests();
        if (test_name.size() == 0) begin
            $display("no tests were found in the test vector file");
            error_count++;
        end
        // Two rising edges in reset, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset      = 1'b0;
        data_valid = 1'b0;
        compare_value("reset_valid", '0, vector_unit_pkg::vector_t'(valid));
        compare_value("reset_result", '0, result);
        idx = 0;
        while (idx < test_name.size()) begin
            if (test_cfg_write[idx]) begin
                write_config(idx);
            end
            drive_op(idx);
            @(negedge clk);
            // Lines without a write follow on the very next cycle
            while (idx + 1 < test_name.size() && !test_cfg_write[idx + 1]) begin
                drive_op(idx + 1);
                collect_result(idx);
                @(negedge clk);
                idx++;
            end
            data_valid = 1'b0;
            collect_result(idx);
            idx++;
        end
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : vector_unit_tb

// ==== bench/vector_unit_tests.txt ====
# Columns: name, config write (0/1), length (0 = 16-bit, 1 = 8-bit), signed (0/1),
# op code (0 ADD 1 SUB 2 SLL 3 SRL 4 SRA 5 EQL 6 LST 7 LST_EQL 8 MIN 9 MAX), A, B, expected (hex)
# Lines without a config write are issued back to back with the line before them
#
# Reset state, 16-bit unsigned; length and signed columns are ignored without a write
reset_default_add    0 1 1 0 00FF00FF 00010001 01000100
add16_wrap           0 0 0 0 1234FFFF 00010001 12350000
sub16_wrap           0 0 0 1 00000005 00010007 FFFFFFFE
sll16_lane_amount    0 0 0 2 00018001 0014000F 00108000
srl16_zero_fill      0 0 0 3 8000F0F0 00030004 10000F0F
sra16_sign_fill      0 0 0 4 80007FF0 00030004 F00007FF
lt16_unsigned        0 0 0 6 80000001 00010002 0000FFFF
#
# 16-bit signed
lt16_signed          1 0 1 6 80000001 00010002 FFFFFFFF
max16_signed         0 0 1 9 80001234 00011234 00011234
min16_signed         0 0 1 8 80000005 0001FFFF 8000FFFF
le16_signed          0 0 1 7 FFFF0003 FFFF0002 FFFF0000
#
# 8-bit unsigned
add8_wrap            1 1 0 0 FF7F01FF 01010101 00800200
sub8_wrap            0 1 0 1 00100080 01010001 FF0F007F
sll8_lane_amount     0 1 0 2 01018181 0F010701 80028002
srl8_zero_fill       0 1 0 3 80FF8010 07040109 010F4008
sra8_sign_fill       0 1 0 4 807F8140 07010302 FF3FF010
eq8_mask             0 1 0 5 11223344 11FF3300 FF00FF00
lt8_unsigned         0 1 0 6 80010203 01800203 00FF0000
min8_unsigned        0 1 0 8 80050A00 01060AFF 01050A00
max8_unsigned        0 1 0 9 80050A00 01060AFF 80060AFF
#
# 8-bit signed
lt8_signed           1 1 1 6 80010203 01800203 FF000000
le8_signed           0 1 1 7 80017FFF 8002807F FFFF00FF
min8_signed          0 1 1 8 80017F05 01FF8005 80FF8005
max8_signed          0 1 1 9 80017F05 01FF8005 01017F05
#
# Back to 16-bit unsigned
eq16_mask            1 0 0 5 ABCD1234 ABCD1235 FFFF0000
max16_unsigned       0 0 0 9 80000001 7FFF0002 80000002
le16_unsigned        0 0 0 7 80000002 00010002 0000FFFF

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the vector unit testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vector_unit_tb -f vector_unit.f \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vvector_unit_tb)"
echo "$sim_output"
echo "$sim_output" | grep -qx "All tests passed" && exit 0 || exit 1

// ==== source/vector_adder_unit.sv ====
// Lane-wise wrap-around add and subtract with carries cut at lane boundaries
module vector_adder_unit (
    input  vector_unit_pkg::vector_t   operand_a_i,
    input  vector_unit_pkg::vector_t   operand_b_i,
    input  vector_unit_pkg::vec_len_t  vector_length_i,
    input  vector_unit_pkg::vunit_op_t operation_i,
    output vector_unit_pkg::vector_t   result_o
);

    localparam int W16 = vector_unit_pkg::LANE16_WIDTH;
    localparam int W8 = vector_unit_pkg::LANE8_WIDTH;

    logic                     subtract;
    vector_unit_pkg::vector_t operand_b_eff;
    vector_unit_pkg::vector_t sum_16;
    vector_unit_pkg::vector_t sum_8;

    // --------------------------------------------------
    // Operand preparation
    // --------------------------------------------------

    // Subtraction is done as A + ~B + 1, the +1 goes in as the carry
    // into every lane separately
    assign subtract      = (operation_i == vector_unit_pkg::OP_SUB);
    assign operand_b_eff = subtract ? ~operand_b_i : operand_b_i;

    // --------------------------------------------------
    // Lane adders
    // --------------------------------------------------

    // Each lane gets its own adder of lane width, so a carry out of the
    // top bit of a lane is simply dropped and never reaches its neighbour
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE16_COUNT; i++) begin
            sum_16[i*W16 +: W16] = operand_a_i[i*W16 +: W16]
                                 + operand_b_eff[i*W16 +: W16]
                                 + vector_unit_pkg::lane16_t'(subtract);
        end
    end

    // Same scheme for the four byte lanes
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE8_COUNT; i++) begin
            sum_8[i*W8 +: W8] = operand_a_i[i*W8 +: W8]
                              + operand_b_eff[i*W8 +: W8]
                              + vector_unit_pkg::lane8_t'(subtract);
        end
    end

    // --------------------------------------------------
    // Output
    // --------------------------------------------------

    // Codes other than OP_SUB leave B untouched, so they come out as the sum
    assign result_o = (vector_length_i == vector_unit_pkg::VEC_LEN_8) ? sum_8 : sum_16;

endmodule : vector_adder_unit

// ==== source/vector_comparison_unit.sv ====
// Lane-wise equal, less, less-or-equal, minimum and maximum
// Signedness comes from the control register
module vector_comparison_unit (
    input  vector_unit_pkg::vector_t   operand_a_i,
    input  vector_unit_pkg::vector_t   operand_b_i,
    input  vector_unit_pkg::vec_len_t  vector_length_i,
    input  vector_unit_pkg::vunit_op_t operation_i,
    input  logic                       signed_operation_i,
    output vector_unit_pkg::vector_t   result_o
);

    localparam int W16 = vector_unit_pkg::LANE16_WIDTH;
    localparam int W8 = vector_unit_pkg::LANE8_WIDTH;

    // Lanes widened by one bit, so one signed compare serves both modes
    logic signed [W16:0] a_ext16;
    logic signed [W16:0] b_ext16;
    logic signed [W8:0]  a_ext8;
    logic signed [W8:0]  b_ext8;

    // Per-format lane masks, each lane all ones or all zeros
    vector_unit_pkg::vector_t eq_mask_16;
    vector_unit_pkg::vector_t lt_mask_16;
    vector_unit_pkg::vector_t gt_mask_16;
    vector_unit_pkg::vector_t eq_mask_8;
    vector_unit_pkg::vector_t lt_mask_8;
    vector_unit_pkg::vector_t gt_mask_8;

    // Masks of the active format
    vector_unit_pkg::vector_t eq_mask;
    vector_unit_pkg::vector_t lt_mask;
    vector_unit_pkg::vector_t gt_mask;

    // --------------------------------------------------
    // Lane compare
    // --------------------------------------------------

    // In signed mode the extra top bit copies the lane sign bit, in unsigned
    // mode it is zero, then a signed compare gives the right order either way
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE16_COUNT; i++) begin
            a_ext16 = {signed_operation_i & operand_a_i[i*W16 + W16 - 1],
                       operand_a_i[i*W16 +: W16]};
            b_ext16 = {signed_operation_i & operand_b_i[i*W16 + W16 - 1],
                       operand_b_i[i*W16 +: W16]};
            eq_mask_16[i*W16 +: W16] = {W16{a_ext16 == b_ext16}};
            lt_mask_16[i*W16 +: W16] = {W16{a_ext16 < b_ext16}};
            gt_mask_16[i*W16 +: W16] = {W16{a_ext16 > b_ext16}};
        end
    end

    // Byte lanes, same trick with a 9-bit compare
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE8_COUNT; i++) begin
            a_ext8 = {signed_operation_i & operand_a_i[i*W8 + W8 - 1], operand_a_i[i*W8 +: W8]};
            b_ext8 = {signed_operation_i & operand_b_i[i*W8 + W8 - 1], operand_b_i[i*W8 +: W8]};
            eq_mask_8[i*W8 +: W8] = {W8{a_ext8 == b_ext8}};
            lt_mask_8[i*W8 +: W8] = {W8{a_ext8 < b_ext8}};
            gt_mask_8[i*W8 +: W8] = {W8{a_ext8 > b_ext8}};
        end
    end

    // Past this point the masks are lane aligned, so the rest of the logic
    // is plain bitwise and does not care about the lane format
    always_comb begin
        if (vector_length_i == vector_unit_pkg::VEC_LEN_8) begin
            eq_mask = eq_mask_8;
            lt_mask = lt_mask_8;
            gt_mask = gt_mask_8;
        end else begin
            eq_mask = eq_mask_16;
            lt_mask = lt_mask_16;
            gt_mask = gt_mask_16;
        end
    end

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------

    always_comb begin
        case (operation_i)
            vector_unit_pkg::OP_LST:     result_o = lt_mask;
            vector_unit_pkg::OP_LST_EQL: result_o = lt_mask | eq_mask;
            // A's lane only where it is strictly smaller, so ties give B's lane
            vector_unit_pkg::OP_MIN:     result_o = (operand_a_i & lt_mask)
                                                  | (operand_b_i & ~lt_mask);
            // A's lane only where it is strictly greater, ties again give B
            vector_unit_pkg::OP_MAX:     result_o = (operand_a_i & gt_mask)
                                                  | (operand_b_i & ~gt_mask);
            // OP_EQL and the codes of the other units
            default:                     result_o = eq_mask;
        endcase
    end

endmodule : vector_comparison_unit

// ==== source/vector_control_register.sv ====
// Vector control register holding lane length and signedness
module vector_control_register (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      cfg_write_i,
    input  vector_unit_pkg::vec_len_t cfg_vector_length_i,
    input  logic                      cfg_signed_i,
    output vector_unit_pkg::vec_len_t vector_length_o,
    output logic                      signed_operation_o
);

    // --------------------------------------------------
    // Configuration state
    // --------------------------------------------------

    // This register is the only place the lane format lives, the
    // datapath units read it and never get a format with each operation
    vector_unit_pkg::vec_len_t vector_length_q;
    logic                      signed_operation_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Out of reset the unit works on two unsigned 16-bit lanes
            vector_length_q    <= vector_unit_pkg::VEC_LEN_16;
            signed_operation_q <= 1'b0;
        end else if (cfg_write_i) begin
            // A write lands at the edge, so an operation issued together
            // with the write still sees the previous setting
            vector_length_q    <= cfg_vector_length_i;
            signed_operation_q <= cfg_signed_i;
        end
    end

    assign vector_length_o    = vector_length_q;
    assign signed_operation_o = signed_operation_q;

endmodule : vector_control_register

// ==== source/vector_shift_unit.sv ====
// Lane-wise logical and arithmetic shifts with a per-lane shift amount
module vector_shift_unit (
    input  vector_unit_pkg::vector_t   operand_a_i,
    input  vector_unit_pkg::vector_t   operand_b_i,
    input  vector_unit_pkg::vec_len_t  vector_length_i,
    input  vector_unit_pkg::vunit_op_t operation_i,
    output vector_unit_pkg::vector_t   result_o
);

    localparam int W16 = vector_unit_pkg::LANE16_WIDTH;
    localparam int W8 = vector_unit_pkg::LANE8_WIDTH;

    // Only as many amount bits as are needed to reach the top of a lane
    localparam int SHAMT16_BITS = $clog2(W16);
    localparam int SHAMT8_BITS = $clog2(W8);

    vector_unit_pkg::vector_t shift_16;
    vector_unit_pkg::vector_t shift_8;

    // --------------------------------------------------
    // 16-bit lanes
    // --------------------------------------------------

    // Lane i of A is shifted by the low 4 bits of lane i of B
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE16_COUNT; i++) begin
            case (operation_i)
                vector_unit_pkg::OP_SLL: begin
                    shift_16[i*W16 +: W16] = operand_a_i[i*W16 +: W16]
                                           << operand_b_i[i*W16 +: SHAMT16_BITS];
                end
                vector_unit_pkg::OP_SRA: begin
                    // The lane is taken as signed so the sign bit fills in
                    shift_16[i*W16 +: W16] = $signed(operand_a_i[i*W16 +: W16])
                                           >>> operand_b_i[i*W16 +: SHAMT16_BITS];
                end
                default: begin
                    // Logical right shift, zero fill
                    shift_16[i*W16 +: W16] = operand_a_i[i*W16 +: W16]
                                           >> operand_b_i[i*W16 +: SHAMT16_BITS];
                end
            endcase
        end
    end

    // --------------------------------------------------
    // 8-bit lanes
    // --------------------------------------------------

    // Byte lanes only look at the low 3 bits of their amount
    always_comb begin
        for (int i = 0; i < vector_unit_pkg::LANE8_COUNT; i++) begin
            case (operation_i)
                vector_unit_pkg::OP_SLL: begin
                    shift_8[i*W8 +: W8] = operand_a_i[i*W8 +: W8]
                                        << operand_b_i[i*W8 +: SHAMT8_BITS];
                end
                vector_unit_pkg::OP_SRA: begin
                    shift_8[i*W8 +: W8] = $signed(operand_a_i[i*W8 +: W8])
                                        >>> operand_b_i[i*W8 +: SHAMT8_BITS];
                end
                default: begin
                    shift_8[i*W8 +: W8] = operand_a_i[i*W8 +: W8]
                                        >> operand_b_i[i*W8 +: SHAMT8_BITS];
                end
            endcase
        end
    end

    assign result_o = (vector_length_i == vector_unit_pkg::VEC_LEN_8) ? shift_8 : shift_16;

endmodule : vector_shift_unit

// ==== source/vector_unit.sv ====
// Top level of the packed-SIMD vector unit
// Control register, three lane-wise units and the one-cycle result stage
module vector_unit (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       cfg_write_i,
    input  vector_unit_pkg::vec_len_t  cfg_vector_length_i,
    input  logic                       cfg_signed_i,
    input  vector_unit_pkg::vector_t   operand_a_i,
    input  vector_unit_pkg::vector_t   operand_b_i,
    input  vector_unit_pkg::vunit_op_t operation_i,
    input  logic                       data_valid_i,
    output vector_unit_pkg::vector_t   result_o,
    output logic                       valid_o
);

    vector_unit_pkg::vec_len_t vector_length;
    logic                      signed_operation;
    vector_unit_pkg::vector_t  adder_result;
    vector_unit_pkg::vector_t  shift_result;
    vector_unit_pkg::vector_t  compare_result;
    vector_unit_pkg::vector_t  unit_result;

    // --------------------------------------------------
    // Configuration and datapath units
    // --------------------------------------------------

    vector_control_register u_control (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .cfg_write_i         (cfg_write_i),
        .cfg_vector_length_i (cfg_vector_length_i),
        .cfg_signed_i        (cfg_signed_i),
        .vector_length_o     (vector_length),
        .signed_operation_o  (signed_operation)
    );

    // All three units see every operation and decode only their own codes
    vector_adder_unit u_adder (
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .vector_length_i (vector_length),
        .operation_i     (operation_i),
        .result_o        (adder_result)
    );

    vector_shift_unit u_shift (
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .vector_length_i (vector_length),
        .operation_i     (operation_i),
        .result_o        (shift_result)
    );

    vector_comparison_unit u_compare (
        .operand_a_i        (operand_a_i),
        .operand_b_i        (operand_b_i),
        .vector_length_i    (vector_length),
        .operation_i        (operation_i),
        .signed_operation_i (signed_operation),
        .result_o           (compare_result)
    );

    // --------------------------------------------------
    // Result select and output stage
    // --------------------------------------------------

    // Pick the unit by operation class, anything past the shifts is a compare
    always_comb begin
        if (operation_i inside {vector_unit_pkg::OP_ADD, vector_unit_pkg::OP_SUB}) begin
            unit_result = adder_result;
        end else if (operation_i inside {vector_unit_pkg::OP_SLL, vector_unit_pkg::OP_SRL,
                                         vector_unit_pkg::OP_SRA}) begin
            unit_result = shift_result;
        end else begin
            unit_result = compare_result;
        end
    end

    // One register stage, so a strobe at one edge gives valid_o at the next.
    // The result holds its value while no operation is issued
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= data_valid_i;
            if (data_valid_i) begin
                result_o <= unit_result;
            end
        end
    end

endmodule : vector_unit

// ==== source/vector_unit_pkg.sv ====
// Shared widths, lane formats and operation codes of the packed-SIMD vector unit
package vector_unit_pkg;

    // --------------------------------------------------
    // Word and lane geometry
    // --------------------------------------------------

    // One operand word is split into two 16-bit lanes or four 8-bit lanes
    localparam int VECTOR_WIDTH = 32;
    localparam int LANE16_COUNT = 2;
    localparam int LANE8_COUNT = 4;

    // Lane widths follow from the word width and the lane count
    localparam int LANE16_WIDTH = VECTOR_WIDTH / LANE16_COUNT;
    localparam int LANE8_WIDTH = VECTOR_WIDTH / LANE8_COUNT;

    typedef logic [VECTOR_WIDTH-1:0] vector_t;
    typedef logic [LANE16_WIDTH-1:0] lane16_t;
    typedef logic [LANE8_WIDTH-1:0] lane8_t;

    // --------------------------------------------------
    // Lane length selector
    // --------------------------------------------------

    typedef logic [0:0] vec_len_t;

    localparam vec_len_t VEC_LEN_16 = 1'b0;
    localparam vec_len_t VEC_LEN_8 = 1'b1;

    // --------------------------------------------------
    // Operation codes
    // --------------------------------------------------

    // The codes are grouped by unit so the top level can steer by range
    typedef logic [3:0] vunit_op_t;

    // Wrap-around arithmetic
    localparam vunit_op_t OP_ADD = 4'd0;
    localparam vunit_op_t OP_SUB = 4'd1;

    // Shifts, amount taken from each lane of the second operand
    localparam vunit_op_t OP_SLL = 4'd2;
    localparam vunit_op_t OP_SRL = 4'd3;
    localparam vunit_op_t OP_SRA = 4'd4;

    // Comparisons and selections
    localparam vunit_op_t OP_EQL = 4'd5;
    localparam vunit_op_t OP_LST = 4'd6;
    localparam vunit_op_t OP_LST_EQL = 4'd7;
    localparam vunit_op_t OP_MIN = 4'd8;
    localparam vunit_op_t OP_MAX = 4'd9;

endpackage : vector_unit_pkg

// ==== vector_unit.f ====
source/vector_unit_pkg.sv
source/vector_control_register.sv
source/vector_adder_unit.sv
source/vector_shift_unit.sv
source/vector_comparison_unit.sv
source/vector_unit.sv
bench/vector_unit_chk.sv
bench/vector_unit_tb.sv
